// File: design/wb_bus_pkg.sv
// Wishbone bus package: address, data and byte-select widths and vector types
package wb_bus_pkg;

  ////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////

  // Byte address width
  localparam int WB_ADDR_W = 32;

  // Data word width
  localparam int WB_DATA_W = 32;

  // One select line per byte lane
  localparam int WB_SEL_W = WB_DATA_W / 8;

  ////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////

  // Byte address as seen on adr
  typedef logic [WB_ADDR_W-1:0] wb_addr_t;

  // Data word on dat_w and dat_r
  typedef logic [WB_DATA_W-1:0] wb_data_t;

  // Byte-lane selects, bit n enables byte n
  typedef logic [WB_SEL_W-1:0] wb_sel_t;

endpackage : wb_bus_pkg

// File: design/pma_pkg.sv
// Physical memory attribute package: fixed address map, region and port kinds
package pma_pkg;
  import wb_bus_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////

  // First RAM byte, RAM depth set by the top level
  localparam wb_addr_t RAM_BASE = 32'h8000_0000;

  // Test-status word, written by the program at the end of a test
  localparam wb_addr_t TOHOST_ADDR = 32'h8000_1000;

  // Character output word
  localparam wb_addr_t UART_TX_ADDR = 32'h8000_1080;

  ////////////////////////////////////////////////////////////////////
  // Decode results
  ////////////////////////////////////////////////////////////////////

  // Region hit by one address
  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_TOHOST,
    REGION_UART,
    REGION_NONE
  } pma_region_e;

  // Which core port a checker guards, picks the access rights
  typedef enum logic {
    PORT_INS,
    PORT_DAT
  } pma_port_e;

endpackage : pma_pkg

// File: design/wb_if.sv
// Classic Wishbone single-transfer link between one master and one slave
interface wb_if;

  // Request side, driven by the master
  logic                  cyc;
  logic                  stb;
  logic                  we;
  wb_bus_pkg::wb_addr_t  adr;
  wb_bus_pkg::wb_data_t  dat_w;
  wb_bus_pkg::wb_sel_t   sel;

  // Response side, driven by the slave
  wb_bus_pkg::wb_data_t  dat_r;
  logic                  ack;
  logic                  err;

  // Master holds request until ack or err
  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack, err
  );

  // Slave answers each request with one ack or one err
  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err
  );

endinterface : wb_if

// File: design/pma_checker.sv
// Per-port PMA checker: decodes the address, checks rights, routes or rejects
module pma_checker
  import wb_bus_pkg::*;
  import pma_pkg::*;
#(
  parameter pma_port_e PORT      = PORT_DAT,
  parameter int        RAM_WORDS = 1024
) (
  input  logic HCLK,
  input  logic rst_n_i,
  wb_if.slave  cpu,
  wb_if.master ram,
  wb_if.master mmio
);

  // One past the last RAM byte
  localparam wb_addr_t RAM_END = RAM_BASE + wb_addr_t'(4 * RAM_WORDS);

  pma_region_e region;
  logic        req;
  logic        misaligned;
  logic        legal;
  logic        to_ram;
  logic        to_mmio;
  logic        err_q;

  ////////////////////////////////////////////////////////////////////
  // Decode and rights
  ////////////////////////////////////////////////////////////////////

  assign req        = cpu.cyc && cpu.stb;
  assign misaligned = |cpu.adr[1:0];

  always_comb begin
    if (cpu.adr >= RAM_BASE && cpu.adr < RAM_END) begin
      region = REGION_RAM;
    end else if (cpu.adr == TOHOST_ADDR) begin
      region = REGION_TOHOST;
    end else if (cpu.adr == UART_TX_ADDR) begin
      region = REGION_UART;
    end else begin
      region = REGION_NONE;
    end
  end

  always_comb begin
    case (region)
      // Fetch port is read only
      REGION_RAM:    legal = (PORT == PORT_DAT) || !cpu.we;
      // MMIO words take full-word data writes only
      REGION_TOHOST,
      REGION_UART:   legal = (PORT == PORT_DAT) && cpu.we && (cpu.sel == '1);
      default:       legal = 1'b0;
    endcase
    if (misaligned) begin
      legal = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Routing
  ////////////////////////////////////////////////////////////////////

  assign to_ram  = req && legal && (region == REGION_RAM);
  assign to_mmio = req && legal && (region != REGION_RAM);

  // RAM side, request only when legal
  assign ram.cyc   = to_ram;
  assign ram.stb   = to_ram;
  assign ram.we    = cpu.we;
  assign ram.adr   = cpu.adr;
  assign ram.dat_w = cpu.dat_w;
  assign ram.sel   = cpu.sel;

  // MMIO side, stays idle on the fetch port
  assign mmio.cyc   = to_mmio;
  assign mmio.stb   = to_mmio;
  assign mmio.we    = cpu.we;
  assign mmio.adr   = cpu.adr;
  assign mmio.dat_w = cpu.dat_w;
  assign mmio.sel   = cpu.sel;

  // Illegal request, one err pulse a cycle later
  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req && !legal && !err_q;
    end
  end

  // Response back to the core
  assign cpu.dat_r = (region == REGION_RAM) ? ram.dat_r : mmio.dat_r;
  assign cpu.ack   = ram.ack || mmio.ack;
  assign cpu.err   = err_q || ram.err || mmio.err;

  // Local err and downstream ack never meet on one transfer
  assert property (@(posedge HCLK) disable iff (!rst_n_i) !(cpu.ack && cpu.err))
    else $error("pma_checker: ack and err together");

endmodule : pma_checker

// File: design/ram_arbiter.sv
// Round-robin arbiter joining the fetch and data masters onto one RAM port
module ram_arbiter
  import wb_bus_pkg::*;
(
  input  logic HCLK,
  input  logic rst_n_i,
  wb_if.slave  ins,
  wb_if.slave  dat,
  wb_if.master ram
);

  logic       req_ins;
  logic       req_dat;
  logic       done;
  // Bit 0 fetch port, bit 1 data port
  logic [1:0] gnt;
  logic [1:0] lock_gnt_q;
  logic       lock_q;
  // Reset to 0 so data wins the first tie
  logic       last_dat_q;

  assign req_ins = ins.cyc && ins.stb;
  assign req_dat = dat.cyc && dat.stb;
  assign done    = ram.ack || ram.err;

  ////////////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      gnt = lock_gnt_q;
    end else if (req_ins && req_dat) begin
      // Tie goes to the port not served last
      gnt = last_dat_q ? 2'b01 : 2'b10;
    end else begin
      gnt = {req_dat, req_ins};
    end
  end

  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      lock_gnt_q <= 2'b00;
      last_dat_q <= 1'b0;
    end else begin
      // Hold grant until the RAM answers
      lock_q     <= ram.cyc && ram.stb && !done;
      lock_gnt_q <= gnt;
      if (done) begin
        last_dat_q <= gnt[1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Request mux and response steering
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    if (gnt[1]) begin
      ram.cyc   = dat.cyc;
      ram.stb   = dat.stb;
      ram.we    = dat.we;
      ram.adr   = dat.adr;
      ram.dat_w = dat.dat_w;
      ram.sel   = dat.sel;
    end else begin
      ram.cyc   = ins.cyc && gnt[0];
      ram.stb   = ins.stb && gnt[0];
      ram.we    = ins.we;
      ram.adr   = ins.adr;
      ram.dat_w = ins.dat_w;
      ram.sel   = ins.sel;
    end
  end

  // Only the granted master sees the answer
  assign ins.ack   = ram.ack && gnt[0];
  assign ins.err   = ram.err && gnt[0];
  assign ins.dat_r = gnt[0] ? ram.dat_r : '0;
  assign dat.ack   = ram.ack && gnt[1];
  assign dat.err   = ram.err && gnt[1];
  assign dat.dat_r = gnt[1] ? ram.dat_r : '0;

  assert property (@(posedge HCLK) disable iff (!rst_n_i) $onehot0(gnt))
    else $error("ram_arbiter: more than one grant");

  // Open RAM transfer keeps its owner
  assert property (@(posedge HCLK) disable iff (!rst_n_i)
                   (ram.cyc && ram.stb && !done) |=> $stable(gnt))
    else $error("ram_arbiter: grant moved during a transfer");

endmodule : ram_arbiter

// File: design/wb_ram.sv
// Word-addressed Wishbone RAM with byte-lane writes and fixed wait states
module wb_ram
  import wb_bus_pkg::*;
#(
  parameter int RAM_WORDS   = 1024,
  parameter int MEM_LATENCY = 1
) (
  input  logic HCLK,
  input  logic rst_n_i,
  wb_if.slave  bus
);

  // Word index width
  localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  // Wait states, 0 to 3
  localparam logic [1:0] LAT = 2'(MEM_LATENCY);

  wb_data_t      mem [RAM_WORDS];
  wb_data_t      rdata_q;
  logic [1:0]    wait_q;
  logic          ack_q;
  logic          req;
  logic          fire;
  logic [AW-1:0] idx;

  assign req  = bus.cyc && bus.stb;
  // Checker keeps the address inside the array
  assign idx  = bus.adr[AW+1:2];
  // Last wait state done, access this edge
  assign fire = req && !ack_q && (wait_q == LAT);

  ////////////////////////////////////////////////////////////////////
  // Wait-state counter and ack
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      wait_q <= 2'd0;
    end else begin
      ack_q <= fire;
      if (fire || !req || ack_q) begin
        wait_q <= 2'd0;
      end else begin
        wait_q <= wait_q + 2'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Array
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (fire) begin
      if (bus.we) begin
        // Selected lanes only
        for (int i = 0; i < $bits(wb_sel_t); i++) begin
          if (bus.sel[i]) begin
            mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
          end
        end
      end
      // Old word on a write, nobody reads it
      rdata_q <= mem[idx];
    end
  end

  assign bus.dat_r = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

  // Ack only inside a live request
  assert property (@(posedge HCLK) disable iff (!rst_n_i) bus.ack |-> (bus.cyc && bus.stb))
    else $error("wb_ram: ack without request");

endmodule : wb_ram

// File: design/mmio_catcher.sv
// MMIO catcher: TOHOST test-status register and UART character strobe
module mmio_catcher
  import wb_bus_pkg::*;
  import pma_pkg::*;
(
  input  logic       HCLK,
  input  logic       rst_n_i,
  wb_if.slave        bus,
  output wb_data_t   tohost_o,
  output logic       test_done_o,
  output logic       test_pass_o,
  output logic       uart_valid_o,
  output logic [7:0] uart_char_o
);

  logic       req;
  logic       wr;
  logic       ack_q;
  wb_data_t   tohost_q;
  logic       uart_valid_q;
  logic [7:0] uart_char_q;

  assign req = bus.cyc && bus.stb;
  // First sampled cycle of a write
  assign wr  = req && bus.we && !ack_q;

  always_ff @(posedge HCLK) begin
    if (!rst_n_i) begin
      ack_q        <= 1'b0;
      tohost_q     <= '0;
      uart_valid_q <= 1'b0;
    end else begin
      // One-cycle ack
      ack_q        <= req && !ack_q;
      uart_valid_q <= wr && (bus.adr == UART_TX_ADDR);
      if (wr && (bus.adr == TOHOST_ADDR)) begin
        tohost_q <= bus.dat_w;
      end
    end
  end

  // Character byte, qualified by the strobe
  always_ff @(posedge HCLK) begin
    if (wr && (bus.adr == UART_TX_ADDR)) begin
      uart_char_q <= bus.dat_w[7:0];
    end
  end

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_r = tohost_q;

  // Status decode, 1 means pass
  assign tohost_o     = tohost_q;
  assign test_done_o  = tohost_q[0];
  assign test_pass_o  = (tohost_q == wb_data_t'(1));
  assign uart_valid_o = uart_valid_q;
  assign uart_char_o  = uart_char_q;

endmodule : mmio_catcher

// File: design/wb_mem_subsys.sv
// Memory subsystem top: two PMA-checked Wishbone ports, shared RAM and MMIO
module wb_mem_subsys
  import wb_bus_pkg::*;
#(
  parameter int RAM_WORDS   = 1024,
  parameter int MEM_LATENCY = 1
) (
  input  logic       HCLK,
  input  logic       rst_n_i,
  // Fetch port
  input  logic       ins_cyc_i,
  input  logic       ins_stb_i,
  input  logic       ins_we_i,
  input  wb_addr_t   ins_adr_i,
  input  wb_data_t   ins_dat_i,
  input  wb_sel_t    ins_sel_i,
  output wb_data_t   ins_dat_o,
  output logic       ins_ack_o,
  output logic       ins_err_o,
  // Data port
  input  logic       dat_cyc_i,
  input  logic       dat_stb_i,
  input  logic       dat_we_i,
  input  wb_addr_t   dat_adr_i,
  input  wb_data_t   dat_dat_i,
  input  wb_sel_t    dat_sel_i,
  output wb_data_t   dat_dat_o,
  output logic       dat_ack_o,
  output logic       dat_err_o,
  // Test status
  output wb_data_t   tohost_o,
  output logic       test_done_o,
  output logic       test_pass_o,
  output logic       uart_valid_o,
  output logic [7:0] uart_char_o
);

  wb_if ins_cpu_if ();
  wb_if dat_cpu_if ();
  wb_if ins_ram_if ();
  wb_if dat_ram_if ();
  wb_if ram_if ();
  wb_if mmio_if ();
  // Unused MMIO side of the fetch checker
  wb_if ins_mmio_if ();

  ////////////////////////////////////////////////////////////////////
  // Core-facing ports
  ////////////////////////////////////////////////////////////////////

  assign ins_cpu_if.cyc   = ins_cyc_i;
  assign ins_cpu_if.stb   = ins_stb_i;
  assign ins_cpu_if.we    = ins_we_i;
  assign ins_cpu_if.adr   = ins_adr_i;
  assign ins_cpu_if.dat_w = ins_dat_i;
  assign ins_cpu_if.sel   = ins_sel_i;
  assign ins_dat_o        = ins_cpu_if.dat_r;
  assign ins_ack_o        = ins_cpu_if.ack;
  assign ins_err_o        = ins_cpu_if.err;

  assign dat_cpu_if.cyc   = dat_cyc_i;
  assign dat_cpu_if.stb   = dat_stb_i;
  assign dat_cpu_if.we    = dat_we_i;
  assign dat_cpu_if.adr   = dat_adr_i;
  assign dat_cpu_if.dat_w = dat_dat_i;
  assign dat_cpu_if.sel   = dat_sel_i;
  assign dat_dat_o        = dat_cpu_if.dat_r;
  assign dat_ack_o        = dat_cpu_if.ack;
  assign dat_err_o        = dat_cpu_if.err;

  // Tie-off, never answers
  assign ins_mmio_if.dat_r = '0;
  assign ins_mmio_if.ack   = 1'b0;
  assign ins_mmio_if.err   = 1'b0;

  ////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////

  pma_checker #(
    .PORT      (pma_pkg::PORT_INS),
    .RAM_WORDS (RAM_WORDS)
  ) u_ins_pma (
    .HCLK    (HCLK),
    .rst_n_i (rst_n_i),
    .cpu     (ins_cpu_if.slave),
    .ram     (ins_ram_if.master),
    .mmio    (ins_mmio_if.master)
  );

  pma_checker #(
    .PORT      (pma_pkg::PORT_DAT),
    .RAM_WORDS (RAM_WORDS)
  ) u_dat_pma (
    .HCLK    (HCLK),
    .rst_n_i (rst_n_i),
    .cpu     (dat_cpu_if.slave),
    .ram     (dat_ram_if.master),
    .mmio    (mmio_if.master)
  );

  ram_arbiter u_arb (
    .HCLK    (HCLK),
    .rst_n_i (rst_n_i),
    .ins     (ins_ram_if.slave),
    .dat     (dat_ram_if.slave),
    .ram     (ram_if.master)
  );

  wb_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_ram (
    .HCLK    (HCLK),
    .rst_n_i (rst_n_i),
    .bus     (ram_if.slave)
  );

  mmio_catcher u_mmio (
    .HCLK         (HCLK),
    .rst_n_i      (rst_n_i),
    .bus          (mmio_if.slave),
    .tohost_o     (tohost_o),
    .test_done_o  (test_done_o),
    .test_pass_o  (test_pass_o),
    .uart_valid_o (uart_valid_o),
    .uart_char_o  (uart_char_o)
  );

endmodule : wb_mem_subsys

// File: verif/tb_clock.sv
// Testbench clock and reset source: 4 ns HCLK, reset low for three cycles
module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic clk = 1'b0;

  // 4 ns period
  always #2 clk = ~clk;
  assign clk_o = clk;

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk);
    // Release on a falling edge like every other input
    @(negedge clk);
    rst_n_o = 1'b1;
  end

endmodule : tb_clock

// File: verif/tb_top.sv
// Memory subsystem testbench: drives both Wishbone ports, checks with assertions
module tb_top
  import wb_bus_pkg::*;
  import pma_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int       RAM_WORDS   = 256;
  localparam int       MEM_LATENCY = 2;
  localparam int       TIMEOUT     = 200;
  localparam wb_addr_t RAM_END     = RAM_BASE + wb_addr_t'(4 * RAM_WORDS);

  logic       HCLK, rst_n;
  logic       ins_cyc, ins_stb, ins_we, ins_ack, ins_err;
  logic       dat_cyc, dat_stb, dat_we, dat_ack, dat_err;
  wb_addr_t   ins_adr, dat_adr;
  wb_data_t   ins_wdat, ins_rdat, dat_wdat, dat_rdat;
  wb_sel_t    ins_sel, dat_sel;
  wb_data_t   tohost;
  logic       test_done, test_pass, uart_valid;
  logic [7:0] uart_char;

  // Reference RAM and predicted responses, set when a request is driven
  wb_data_t   ref_mem [RAM_WORDS];
  bit         ins_exp_err, dat_exp_err, dat_exp_we, exp_uart, hung;
  wb_data_t   ins_exp_rdat, dat_exp_rdat, exp_tohost;
  logic [7:0] exp_char;
  int         errors, test_errs, test_no, xfers;
  time        ins_done_t, dat_done_t;

  tb_clock u_clk (.clk_o(HCLK), .rst_n_o(rst_n));

  wb_mem_subsys #(.RAM_WORDS(RAM_WORDS), .MEM_LATENCY(MEM_LATENCY)) DUT (
    .HCLK(HCLK), .rst_n_i(rst_n),
    .ins_cyc_i(ins_cyc), .ins_stb_i(ins_stb), .ins_we_i(ins_we), .ins_adr_i(ins_adr),
    .ins_dat_i(ins_wdat), .ins_sel_i(ins_sel), .ins_dat_o(ins_rdat),
    .ins_ack_o(ins_ack), .ins_err_o(ins_err),
    .dat_cyc_i(dat_cyc), .dat_stb_i(dat_stb), .dat_we_i(dat_we), .dat_adr_i(dat_adr),
    .dat_dat_i(dat_wdat), .dat_sel_i(dat_sel), .dat_dat_o(dat_rdat),
    .dat_ack_o(dat_ack), .dat_err_o(dat_err),
    .tohost_o(tohost), .test_done_o(test_done), .test_pass_o(test_pass),
    .uart_valid_o(uart_valid), .uart_char_o(uart_char)
  );

  function automatic void flag_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Response checks
  //////////////////////////////////////////////////////////////////////

  // Ack only on legal requests, err only on illegal ones
  assert property (@(posedge HCLK) disable iff (!rst_n) dat_ack |-> !dat_exp_err)
    else flag_error("data port ack on an illegal access");
  assert property (@(posedge HCLK) disable iff (!rst_n) dat_err |-> dat_exp_err)
    else flag_error("data port err on a legal access");
  assert property (@(posedge HCLK) disable iff (!rst_n) ins_ack |-> !ins_exp_err)
    else flag_error("fetch port ack on an illegal access");
  assert property (@(posedge HCLK) disable iff (!rst_n) ins_err |-> ins_exp_err)
    else flag_error("fetch port err on a legal access");

  // Read data against the byte-merged model
  assert property (@(posedge HCLK) disable iff (!rst_n)
                   (dat_ack && !dat_exp_we) |-> (dat_rdat == dat_exp_rdat))
    else flag_error($sformatf("data read %h, expected %h", $sampled(dat_rdat), dat_exp_rdat));
  assert property (@(posedge HCLK) disable iff (!rst_n) ins_ack |-> (ins_rdat == ins_exp_rdat))
    else flag_error($sformatf("fetch read %h, expected %h", $sampled(ins_rdat), ins_exp_rdat));

  // Status outputs follow the last full TOHOST write, 1 means pass
  assert property (@(posedge HCLK) disable iff (!rst_n)
                   (dat_ack || !dat_cyc) |-> (tohost == exp_tohost &&
                   test_done == exp_tohost[0] && test_pass == (exp_tohost == 32'd1)))
    else flag_error($sformatf("tohost %h, expected %h", $sampled(tohost), exp_tohost));

  // One UART strobe per UART write, with its low byte
  assert property (@(posedge HCLK) disable iff (!rst_n)
                   (dat_ack && exp_uart) |-> (uart_valid && uart_char == exp_char))
    else flag_error("UART strobe missing or wrong character");
  assert property (@(posedge HCLK) disable iff (!rst_n) uart_valid |-> (dat_ack && exp_uart))
    else flag_error("UART strobe without a UART write");

  //////////////////////////////////////////////////////////////////////
  // Reference rules and port driving
  //////////////////////////////////////////////////////////////////////

  // Address map rights, as the PMA rules state them
  function automatic bit predict_err(input bit is_ins, input bit we, input wb_addr_t adr,
                                     input wb_sel_t sel);
    if (adr[1:0] != 2'b00) return 1'b1;
    if (adr >= RAM_BASE && adr < RAM_END) return is_ins && we;
    if (adr == TOHOST_ADDR || adr == UART_TX_ADDR) return is_ins || !we || sel != 4'hF;
    return 1'b1;
  endfunction

  function automatic wb_data_t merge_lanes(input wb_data_t old, input wb_data_t wdat,
                                           input wb_sel_t sel);
    wb_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = wdat[8*b +: 8];
    end
    return res;
  endfunction

  function automatic wb_addr_t word_addr(input int w);
    return RAM_BASE + wb_addr_t'(4 * w);
  endfunction

  function automatic void drive_port(input bit is_ins, input bit req, input bit we,
                                     input wb_addr_t adr, input wb_data_t wdat,
                                     input wb_sel_t sel);
    if (is_ins) begin
      {ins_cyc, ins_stb, ins_we, ins_adr, ins_wdat, ins_sel} = {req, req, we, adr, wdat, sel};
    end else begin
      {dat_cyc, dat_stb, dat_we, dat_adr, dat_wdat, dat_sel} = {req, req, we, adr, wdat, sel};
    end
  endfunction

  // One transfer: predict, drive on a falling edge, wait for ack or err
  task automatic access(input bit is_ins, input bit we, input wb_addr_t adr,
                        input wb_data_t wdat, input wb_sel_t sel);
    bit       bad;
    bit       in_ram;
    bit       seen;
    int       idx;
    int       waited;
    wb_data_t exp_rd;
    if (!hung) begin
      bad    = predict_err(is_ins, we, adr, sel);
      in_ram = adr >= RAM_BASE && adr < RAM_END;
      idx    = int'((adr - RAM_BASE) >> 2);
      exp_rd = '0;
      @(negedge HCLK);
      if (in_ram) exp_rd = ref_mem[idx];
      if (is_ins) begin
        ins_exp_err  = bad;
        ins_exp_rdat = exp_rd;
      end else begin
        dat_exp_err  = bad;
        dat_exp_we   = we;
        dat_exp_rdat = exp_rd;
        exp_uart     = !bad && adr == UART_TX_ADDR;
        if (exp_uart) exp_char = wdat[7:0];
        if (!bad && adr == TOHOST_ADDR) exp_tohost = wdat;
      end
      if (!bad && in_ram && we) ref_mem[idx] = merge_lanes(ref_mem[idx], wdat, sel);
      drive_port(is_ins, 1'b1, we, adr, wdat, sel);
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < TIMEOUT) begin
        @(negedge HCLK);
        waited++;
        seen = is_ins ? (ins_ack || ins_err) : (dat_ack || dat_err);
      end
      if (!seen) begin
        hung = 1'b1;
        $display("Timeout at %0t: %s port got no ack or err in %0d cycles", $time,
                 is_ins ? "fetch" : "data", TIMEOUT);
      end else if (is_ins) begin
        ins_done_t = $time;
      end else begin
        dat_done_t = $time;
      end
      // Held across the rising edge that samples the response
      @(negedge HCLK);
      drive_port(is_ins, 1'b0, 1'b0, '0, '0, '0);
      xfers++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %0d error(s)", test_no, name, errors - test_errs);
    test_no++;
    test_errs = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned kind;
    int          waited;
    wb_addr_t    adr;
    time         pair_t;
    void'($urandom(32'h3550));
    drive_port(1'b1, 1'b0, 1'b0, '0, '0, '0);
    drive_port(1'b0, 1'b0, 1'b0, '0, '0, '0);
    errors     = 0;
    test_errs  = 0;
    xfers      = 0;
    hung       = 1'b0;
    exp_uart   = 1'b0;
    exp_tohost = '0;
    test_no    = 1;
    waited     = 0;
    while (rst_n !== 1'b1 && waited < TIMEOUT) begin
      @(negedge HCLK);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      hung = 1'b1;
      $display("Reset was never released");
    end
    // Fill pattern from the full byte address
    for (int w = 0; w < RAM_WORDS; w++) begin
      adr = word_addr(w);
      access(1'b0, 1'b1, adr, adr ^ {adr[15:0], adr[31:16]} ^ 32'h5A5A_C3C3, 4'hF);
    end
    for (int k = 0; k < 16; k++) access(1'b0, 1'b1, word_addr(3 * k), $urandom, wb_sel_t'(k));
    for (int k = 0; k < 16; k++) access(1'b0, 1'b0, word_addr(3 * k), '0, 4'hF);
    end_test("byte-lane writes and read-back");
    // Fetch the word written by the previous pair, both ports at once
    for (int k = 0; k < 20; k++) begin
      pair_t = $time;
      fork
        access(1'b1, 1'b0, word_addr(99 + k), '0, 4'hF);
        access(1'b0, 1'b1, word_addr(100 + k), $urandom, 4'hF);
      join
      // Data port was served last before every pair, so the fetch wins the tie
      assert (ins_done_t > pair_t && dat_done_t > ins_done_t)
        else flag_error("contended pair not served fetch first, then data");
    end
    end_test("contended fetch and data");
    access(1'b1, 1'b0, TOHOST_ADDR, '0, 4'hF);
    access(1'b1, 1'b1, word_addr(5), 32'hDEAD_BEEF, 4'hF);
    access(1'b0, 1'b0, UART_TX_ADDR, '0, 4'hF);
    access(1'b0, 1'b1, TOHOST_ADDR, 32'd1, 4'h3);
    access(1'b0, 1'b0, RAM_END, '0, 4'hF);
    access(1'b0, 1'b1, RAM_END + 32'h40, 32'h0BAD_F00D, 4'hF);
    access(1'b0, 1'b1, word_addr(6) + 32'd2, 32'h1234_5678, 4'hF);
    access(1'b1, 1'b0, word_addr(7) + 32'd1, '0, 4'hF);
    for (int w = 5; w < 8; w++) access(1'b0, 1'b0, word_addr(w), '0, 4'hF);
    end_test("PMA errors");
    access(1'b0, 1'b1, UART_TX_ADDR, 32'h1234_5641, 4'hF);
    access(1'b0, 1'b1, UART_TX_ADDR, 32'h0000_000A, 4'hF);
    end_test("UART character");
    access(1'b0, 1'b1, TOHOST_ADDR, 32'd1, 4'hF);
    access(1'b0, 1'b1, TOHOST_ADDR, 32'd5, 4'hF);
    end_test("TOHOST status");
    for (int n = 0; n < 200; n++) begin
      kind = $urandom_range(5, 0);
      case (kind)
        0, 1, 2: adr = word_addr(int'($urandom_range(RAM_WORDS - 1, 0)));
        3:       adr = word_addr(int'($urandom_range(RAM_WORDS - 1, 0))) + $urandom_range(3, 1);
        4:       adr = ($urandom_range(1, 0) == 0) ? TOHOST_ADDR : UART_TX_ADDR;
        default: adr = $urandom;
      endcase
      access(bit'($urandom_range(1, 0)), bit'($urandom_range(1, 0)), adr, $urandom,
             wb_sel_t'($urandom_range(15, 0)));
    end
    // Sweep the whole RAM through the fetch port
    for (int w = 0; w < RAM_WORDS; w++) access(1'b1, 1'b0, word_addr(w), '0, 4'hF);
    end_test("random accesses");
    $display("tests %0d, transfers %0d, errors %0d%s", test_no - 1, xfers, errors,
             hung ? ", run stalled" : "");
    if (errors == 0 && !hung) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_top

// File: tb.f
design/wb_bus_pkg.sv
design/pma_pkg.sv
design/wb_if.sv
design/pma_checker.sv
design/ram_arbiter.sv
design/wb_ram.sv
design/mmio_catcher.sv
design/wb_mem_subsys.sv
verif/tb_clock.sv
verif/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_top -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null \
  && exit 0 \
  || exit 1
